/* src/dmm_ctl_pkg.sv */
// shared definitions for the multimeter control FPGA
// widths, register indices, mode and opcode enums, mux codes, timing constants
`default_nettype none

package dmm_ctl_pkg;

  //////////////////////////////
  // widths

  localparam int NUM_BITS       = 22;
  localparam int REG_WIDTH      = 24;
  localparam int NUM_PERIPH     = 8;
  localparam int MUX_WIDTH      = 4;
  localparam int MONITOR_WIDTH  = 8;
  localparam int MODE_WIDTH     = 2;

  // spi frame is one address byte then the data word
  localparam int ADDR_BITS      = 8;
  localparam int ADDR_WIDTH     = 7;
  localparam int FRAME_BITS     = ADDR_BITS + REG_WIDTH;
  localparam int WRITE_FLAG     = 7;
  // wide enough to count past FRAME_BITS without wrapping
  localparam int BIT_CNT_WIDTH  = 6;
  localparam int SYNC_STAGES    = 2;

  // 4094 strobe is active high, the remaining selects are active low
  localparam logic [NUM_PERIPH-1:0] CS_POLARITY = 8'b0000_0001;

  //////////////////////////////
  // register indices

  typedef enum logic [ADDR_WIDTH-1:0] {
    ADDR_LED          = 7'd1,
    ADDR_SPI_MUX      = 7'd2,
    ADDR_4094         = 7'd3,
    ADDR_MODE         = 7'd4,
    ADDR_TEST_PATTERN = 7'd5
  } reg_addr_t;

  // source of the control word
  typedef enum logic [MODE_WIDTH-1:0] {
    MODE_PATTERN = 2'd0,
    MODE_MCU     = 2'd1,
    MODE_COUNTER = 2'd2,
    MODE_CHARGE  = 2'd3
  } mode_t;

  //////////////////////////////
  // mux codes, bit 3 is the enable

  // enable, s2 routes himux2 through
  localparam logic [MUX_WIDTH-1:0] HIMUX_SEL_HIMUX2 = 4'b1001;
  // s4 ground, clears charge on the cap
  localparam logic [MUX_WIDTH-1:0] HIMUX2_SEL_GND   = 4'b1011;
  // s1 dcv source hi
  localparam logic [MUX_WIDTH-1:0] HIMUX2_SEL_DCV   = 4'b1000;

  // timing, one second per phase at 20 MHz
  localparam int CHARGE_PHASE_CYCLES = 20_000_000;
  localparam int PHASE_CNT_WIDTH     = 25;
  localparam int BLINK_BIT           = 21;

  //////////////////////////////
  // field positions in the control word

  localparam int AZMUX_LSB   = 0;
  localparam int HIMUX_LSB   = 4;
  localparam int HIMUX2_LSB  = 8;
  localparam int PC_SW_BIT   = 12;
  localparam int LED_BIT     = 13;
  localparam int MONITOR_LSB = 14;

endpackage

`default_nettype wire

/* src/spi_reg_bank.sv */
// spi slave sampled in the clk domain
// pin synchronizers, 32-bit frame shifter, read shifter
// and the five control registers with readback
`timescale 1ns/100ps
`default_nettype none

module spi_reg_bank import dmm_ctl_pkg::*; (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  spi_sclk,
  input  wire                  spi_cs_n,
  input  wire                  spi_mosi,
  output logic                 reg_dout,
  output logic [REG_WIDTH-1:0] reg_spi_mux,
  output logic [REG_WIDTH-1:0] reg_4094,
  output logic [REG_WIDTH-1:0] reg_led,
  output logic [REG_WIDTH-1:0] reg_test_pattern,
  output mode_t                reg_mode
);

  //////////////////////////////
  // pin synchronizers

  logic [SYNC_STAGES-1:0] sclk_sync;
  logic [SYNC_STAGES-1:0] cs_sync;
  logic [SYNC_STAGES-1:0] mosi_sync;
  logic                   sclk_prev;
  logic                   cs_prev;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      sclk_sync <= '0;
      // chip select idles high
      cs_sync   <= '1;
      mosi_sync <= '0;
      sclk_prev <= 1'b0;
      cs_prev   <= 1'b1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], spi_sclk};
      cs_sync   <= {cs_sync[SYNC_STAGES-2:0], spi_cs_n};
      mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], spi_mosi};
      sclk_prev <= sclk_sync[SYNC_STAGES-1];
      cs_prev   <= cs_sync[SYNC_STAGES-1];
    end
  end

  logic sclk_s;
  logic cs_s;
  logic mosi_s;
  assign sclk_s = sclk_sync[SYNC_STAGES-1];
  assign cs_s   = cs_sync[SYNC_STAGES-1];
  assign mosi_s = mosi_sync[SYNC_STAGES-1];

  // edges only count while the frame is selected
  logic sclk_rise;
  logic sclk_fall;
  logic cs_fall;
  logic cs_rise;
  assign sclk_rise = ~cs_s & sclk_s & ~sclk_prev;
  assign sclk_fall = ~cs_s & ~sclk_s & sclk_prev;
  assign cs_fall   = ~cs_s & cs_prev;
  assign cs_rise   = cs_s & ~cs_prev;

  //////////////////////////////
  // frame shifter and bit count

  logic [FRAME_BITS-1:0]    frame_sr;
  logic [REG_WIDTH-1:0]     rd_sr;
  logic [REG_WIDTH-1:0]     rd_value;
  logic [BIT_CNT_WIDTH-1:0] bit_cnt;
  logic                     commit_pending;

  // mode 0, mosi taken on the rising sclk
  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      frame_sr <= {frame_sr[FRAME_BITS-2:0], mosi_s};
  end

  // miso moves on the falling sclk, the first fall after the address loads it
  always_ff @(posedge clk)
  begin
    if (cs_fall)
      rd_sr <= '0;
    else if (sclk_fall)
    begin
      if (bit_cnt == BIT_CNT_WIDTH'(ADDR_BITS))
        rd_sr <= rd_value;
      else
        rd_sr <= {rd_sr[REG_WIDTH-2:0], 1'b0};
    end
  end

  assign reg_dout = rd_sr[REG_WIDTH-1];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      bit_cnt        <= '0;
      commit_pending <= 1'b0;
    end
    else
    begin
      if (cs_fall)
        bit_cnt <= '0;
      // stops one past a full frame so long frames stay rejected
      else if (sclk_rise && bit_cnt <= BIT_CNT_WIDTH'(FRAME_BITS))
        bit_cnt <= bit_cnt + 1'b1;
      // write only on an exact frame with the write flag set
      commit_pending <= cs_rise && (bit_cnt == BIT_CNT_WIDTH'(FRAME_BITS))
                        && frame_sr[REG_WIDTH + WRITE_FLAG];
    end
  end

  //////////////////////////////
  // registers

  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [REG_WIDTH-1:0]  wr_data;
  assign rd_addr = frame_sr[ADDR_WIDTH-1:0];
  assign wr_addr = frame_sr[REG_WIDTH +: ADDR_WIDTH];
  assign wr_data = frame_sr[REG_WIDTH-1:0];

  // readback, unknown index reads zero
  always_comb
  begin
    case (reg_addr_t'(rd_addr))
      ADDR_LED:          rd_value = reg_led;
      ADDR_SPI_MUX:      rd_value = reg_spi_mux;
      ADDR_4094:         rd_value = reg_4094;
      ADDR_MODE:         rd_value = REG_WIDTH'(reg_mode);
      ADDR_TEST_PATTERN: rd_value = reg_test_pattern;
      default:           rd_value = '0;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      reg_led          <= '0;
      reg_spi_mux      <= '0;
      reg_4094         <= '0;
      reg_test_pattern <= '0;
      // mcu mode with a zero word keeps every pin low
      reg_mode         <= MODE_MCU;
    end
    else if (commit_pending)
    begin
      case (reg_addr_t'(wr_addr))
        ADDR_LED:          reg_led <= wr_data;
        ADDR_SPI_MUX:      reg_spi_mux <= wr_data;
        ADDR_4094:         reg_4094 <= wr_data;
        ADDR_MODE:         reg_mode <= mode_t'(wr_data[MODE_WIDTH-1:0]);
        ADDR_TEST_PATTERN: reg_test_pattern <= wr_data;
        default:           ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/spi_periph_route.sv */
// routing of the second chip select to the external shift-register peripherals
// and arbitration of the miso pin
`timescale 1ns/100ps
`default_nettype none

module spi_periph_route import dmm_ctl_pkg::*; (
  input  wire                   spi_sclk,
  input  wire                   spi_cs2_n,
  input  wire                   spi_mosi,
  input  wire                   spi_cs_n,
  input  wire                   reg_dout,
  input  wire  [NUM_PERIPH-1:0] reg_spi_mux,
  input  wire  [NUM_PERIPH-1:0] spi_miso_vec,
  output logic [NUM_PERIPH-1:0] spi_cs_vec,
  output logic [NUM_PERIPH-1:0] spi_sclk_vec,
  output logic [NUM_PERIPH-1:0] spi_mosi_vec,
  output logic                  spi_miso
);

  // peripherals picked by the mux register while cs2 is asserted
  logic [NUM_PERIPH-1:0] sel_vec;
  assign sel_vec = reg_spi_mux & {NUM_PERIPH{~spi_cs2_n}};

  // selected bit takes its active level, the rest sit inactive
  assign spi_cs_vec = CS_POLARITY ^ ~sel_vec;

  // clock and data only reach selected peripherals
  assign spi_sclk_vec = sel_vec & {NUM_PERIPH{spi_sclk}};
  assign spi_mosi_vec = sel_vec & {NUM_PERIPH{spi_mosi}};

  // register bank wins while its own chip select is low
  always_comb
  begin
    if (!spi_cs_n)
      spi_miso = reg_dout;
    else if (!spi_cs2_n)
      spi_miso = |(spi_miso_vec & sel_vec);
    else
      spi_miso = 1'b0;
  end

endmodule

`default_nettype wire

/* src/pattern_gen.sv */
// free-running counter feeding the counter word and the blink test pattern
`timescale 1ns/100ps
`default_nettype none

module pattern_gen import dmm_ctl_pkg::*; (
  input  wire                 clk,
  input  wire                 reset,
  output logic [NUM_BITS-1:0] counter_word,
  output logic [NUM_BITS-1:0] pattern_word
);

  logic [NUM_BITS-1:0] count;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      count <= '0;
    else
      count <= count + 1'b1;
  end

  // counter mode shows the raw count on every pin
  assign counter_word = count;

  // pattern mode, muxes and pre-charge off
  always_comb
  begin
    pattern_word = '0;
    // monitor pins step with the low byte
    pattern_word[MONITOR_LSB +: MONITOR_WIDTH] = count[MONITOR_WIDTH-1:0];
    // slow blink on the led
    pattern_word[LED_BIT] = count[BLINK_BIT];
  end

endmodule

`default_nettype wire

/* src/charge_sequencer.sv */
// accumulation-capacitor charge test
// alternates a discharge phase to ground with a charge phase from the dcv source
`timescale 1ns/100ps
`default_nettype none

module charge_sequencer import dmm_ctl_pkg::*; #(
  parameter int phase_cycles = CHARGE_PHASE_CYCLES
) (
  input  wire                 clk,
  input  wire                 reset,
  output logic [NUM_BITS-1:0] charge_word
);

  //////////////////////////////
  // phase timer

  logic [PHASE_CNT_WIDTH-1:0] phase_cnt;
  // low is discharge, high is charge
  logic                       charging;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      phase_cnt <= '0;
      charging  <= 1'b0;
    end
    else if (phase_cnt == PHASE_CNT_WIDTH'(phase_cycles - 1))
    begin
      // end of phase, swap and start over
      phase_cnt <= '0;
      charging  <= ~charging;
    end
    else
      phase_cnt <= phase_cnt + 1'b1;
  end

  //////////////////////////////
  // control word

  always_comb
  begin
    // azmux, pre-charge and monitor stay zero
    charge_word = '0;
    // himux passes himux2 through in both phases
    charge_word[HIMUX_LSB +: MUX_WIDTH] = HIMUX_SEL_HIMUX2;
    if (charging)
    begin
      // cap charges from the dcv source, led on to show it
      charge_word[HIMUX2_LSB +: MUX_WIDTH] = HIMUX2_SEL_DCV;
      charge_word[LED_BIT] = 1'b1;
    end
    else
    begin
      // ground clears the cap
      charge_word[HIMUX2_LSB +: MUX_WIDTH] = HIMUX2_SEL_GND;
      charge_word[LED_BIT] = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/output_select.sv */
// mode-driven selection of the control word
// registered so the pins change cleanly, then split into pin fields
`timescale 1ns/100ps
`default_nettype none

module output_select import dmm_ctl_pkg::*; (
  input  wire                      clk,
  input  wire                      reset,
  input  mode_t                    reg_mode,
  input  wire  [NUM_BITS-1:0]      pattern_word,
  input  wire  [NUM_BITS-1:0]      mcu_word,
  input  wire  [NUM_BITS-1:0]      counter_word,
  input  wire  [NUM_BITS-1:0]      charge_word,
  output logic [MUX_WIDTH-1:0]     azmux_ctl,
  output logic [MUX_WIDTH-1:0]     himux_ctl,
  output logic [MUX_WIDTH-1:0]     himux2_ctl,
  output logic                     pc_sw_ctl,
  output logic                     led,
  output logic [MONITOR_WIDTH-1:0] monitor
);

  logic [NUM_BITS-1:0] sel_word;
  logic [NUM_BITS-1:0] ctl_word;

  // four-way source pick
  always_comb
  begin
    case (reg_mode)
      MODE_PATTERN: sel_word = pattern_word;
      MODE_MCU:     sel_word = mcu_word;
      MODE_COUNTER: sel_word = counter_word;
      MODE_CHARGE:  sel_word = charge_word;
      default:      sel_word = '0;
    endcase
  end

  // all pins low out of reset
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ctl_word <= '0;
    else
      ctl_word <= sel_word;
  end

  // pin fields
  assign azmux_ctl  = ctl_word[AZMUX_LSB +: MUX_WIDTH];
  assign himux_ctl  = ctl_word[HIMUX_LSB +: MUX_WIDTH];
  assign himux2_ctl = ctl_word[HIMUX2_LSB +: MUX_WIDTH];
  assign pc_sw_ctl  = ctl_word[PC_SW_BIT];
  assign led        = ctl_word[LED_BIT];
  assign monitor    = ctl_word[MONITOR_LSB +: MONITOR_WIDTH];

endmodule

`default_nettype wire

/* src/dmm_ctl_top.sv */
// top level of the multimeter control FPGA
// spi register bank, peripheral routing, word sources and pin output
`timescale 1ns/100ps
`default_nettype none

module dmm_ctl_top import dmm_ctl_pkg::*; #(
  parameter int phase_cycles = CHARGE_PHASE_CYCLES
) (
  input  wire                       clk,
  input  wire                       reset,
  // mcu spi
  input  wire                       spi_sclk,
  input  wire                       spi_cs_n,
  input  wire                       spi_cs2_n,
  input  wire                       spi_mosi,
  output logic                      spi_miso,
  // peripheral spi fan-out
  input  wire  [NUM_PERIPH-1:0]     spi_miso_vec,
  output logic [NUM_PERIPH-1:0]     spi_cs_vec,
  output logic [NUM_PERIPH-1:0]     spi_sclk_vec,
  output logic [NUM_PERIPH-1:0]     spi_mosi_vec,
  output logic                      oe_4094,
  // analog control pins
  output logic [MUX_WIDTH-1:0]      azmux_ctl,
  output logic [MUX_WIDTH-1:0]      himux_ctl,
  output logic [MUX_WIDTH-1:0]      himux2_ctl,
  output logic                      pc_sw_ctl,
  output logic                      led,
  output logic [MONITOR_WIDTH-1:0]  monitor
);

  logic                 reg_dout;
  logic [REG_WIDTH-1:0] reg_spi_mux;
  logic [REG_WIDTH-1:0] reg_4094;
  logic [REG_WIDTH-1:0] reg_test_pattern;
  mode_t                reg_mode;
  logic [NUM_BITS-1:0]  counter_word;
  logic [NUM_BITS-1:0]  pattern_word;
  logic [NUM_BITS-1:0]  charge_word;

  //////////////////////////////
  // spi

  // led register is readback storage only, nothing drives a pin from it
  spi_reg_bank spi_reg_bank_inst (
    .clk              (clk),
    .reset            (reset),
    .spi_sclk         (spi_sclk),
    .spi_cs_n         (spi_cs_n),
    .spi_mosi         (spi_mosi),
    .reg_dout         (reg_dout),
    .reg_spi_mux      (reg_spi_mux),
    .reg_4094         (reg_4094),
    .reg_led          (),
    .reg_test_pattern (reg_test_pattern),
    .reg_mode         (reg_mode)
  );

  spi_periph_route spi_periph_route_inst (
    .spi_sclk     (spi_sclk),
    .spi_cs2_n    (spi_cs2_n),
    .spi_mosi     (spi_mosi),
    .spi_cs_n     (spi_cs_n),
    .reg_dout     (reg_dout),
    .reg_spi_mux  (reg_spi_mux[NUM_PERIPH-1:0]),
    .spi_miso_vec (spi_miso_vec),
    .spi_cs_vec   (spi_cs_vec),
    .spi_sclk_vec (spi_sclk_vec),
    .spi_mosi_vec (spi_mosi_vec),
    .spi_miso     (spi_miso)
  );

  // 4094 output enable under mcu control
  assign oe_4094 = reg_4094[0];

  //////////////////////////////
  // word sources and output

  pattern_gen pattern_gen_inst (
    .clk          (clk),
    .reset        (reset),
    .counter_word (counter_word),
    .pattern_word (pattern_word)
  );

  charge_sequencer #(
    .phase_cycles (phase_cycles)
  ) charge_sequencer_inst (
    .clk         (clk),
    .reset       (reset),
    .charge_word (charge_word)
  );

  // mcu word is the low part of the test pattern register
  output_select output_select_inst (
    .clk          (clk),
    .reset        (reset),
    .reg_mode     (reg_mode),
    .pattern_word (pattern_word),
    .mcu_word     (reg_test_pattern[NUM_BITS-1:0]),
    .counter_word (counter_word),
    .charge_word  (charge_word),
    .azmux_ctl    (azmux_ctl),
    .himux_ctl    (himux_ctl),
    .himux2_ctl   (himux2_ctl),
    .pc_sw_ctl    (pc_sw_ctl),
    .led          (led),
    .monitor      (monitor)
  );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
// clock and reset generator for the testbench
// 20 ns clock, reset held for 5 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);

  localparam int HALF_PERIOD_NS = 10;
  localparam int RESET_CYCLES   = 5;

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // release lands just after an edge, like the other inputs
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

/* tb/dmm_ctl_tb.sv */
// testbench for the multimeter control FPGA
// spi master tasks, register model, random stimulus,
// routing, counter, pattern and charge checks, watchdog and summary
`timescale 1ns/100ps
`default_nettype none

module dmm_ctl_tb import dmm_ctl_pkg::*; ();

  //////////////////////////////
  // run length

  localparam int SPI_HALF      = 8;
  localparam int SETTLE_CYCLES = 10;
  localparam int CLK_PERIOD_NS = 20;
  localparam int NUM_RANDOM    = 40;
  localparam int NUM_MCU_WORDS = 4;
  localparam int NUM_ROUTES    = 12;
  localparam int SAMPLE_GAP    = 37;
  localparam int NUM_SAMPLES   = 20;
  localparam int CHARGE_GAP    = 50;
  localparam int CHARGE_SPAN   = 1000;
  localparam int FRAME_CYCLES  = 2 * SPI_HALF * FRAME_BITS + 2 * SPI_HALF + SETTLE_CYCLES;
  // reset reads, random pairs, mcu words, routes, mode writes
  localparam int NUM_FRAMES    = 8 + 2 * NUM_RANDOM + 1 + 2 * NUM_MCU_WORDS + NUM_ROUTES + 3;
  localparam int CHECK_CYCLES  = 2 * SAMPLE_GAP * NUM_SAMPLES + CHARGE_SPAN + 1000;
  localparam int TIMEOUT_NS    = (NUM_FRAMES * 2 * FRAME_CYCLES + CHECK_CYCLES) * CLK_PERIOD_NS;

  logic                     clk;
  logic                     reset;
  logic                     spi_sclk;
  logic                     spi_cs_n;
  logic                     spi_cs2_n;
  logic                     spi_mosi;
  logic                     spi_miso;
  logic [NUM_PERIPH-1:0]    spi_miso_vec;
  logic [NUM_PERIPH-1:0]    spi_cs_vec;
  logic [NUM_PERIPH-1:0]    spi_sclk_vec;
  logic [NUM_PERIPH-1:0]    spi_mosi_vec;
  logic                     oe_4094;
  logic [MUX_WIDTH-1:0]     azmux_ctl;
  logic [MUX_WIDTH-1:0]     himux_ctl;
  logic [MUX_WIDTH-1:0]     himux2_ctl;
  logic                     pc_sw_ctl;
  logic                     led;
  logic [MONITOR_WIDTH-1:0] monitor;

  // expected register contents by index
  logic [REG_WIDTH-1:0] model [0:(1 << ADDR_WIDTH)-1];
  integer               seed;
  int                   errors;
  int                   checks;

  tb_clock tb_clock_inst (
    .clk   (clk),
    .reset (reset)
  );

  // short phases so both charge words show up quickly
  dmm_ctl_top #(
    .phase_cycles (200)
  ) dmm_ctl_top_inst (
    .clk          (clk),
    .reset        (reset),
    .spi_sclk     (spi_sclk),
    .spi_cs_n     (spi_cs_n),
    .spi_cs2_n    (spi_cs2_n),
    .spi_mosi     (spi_mosi),
    .spi_miso     (spi_miso),
    .spi_miso_vec (spi_miso_vec),
    .spi_cs_vec   (spi_cs_vec),
    .spi_sclk_vec (spi_sclk_vec),
    .spi_mosi_vec (spi_mosi_vec),
    .oe_4094      (oe_4094),
    .azmux_ctl    (azmux_ctl),
    .himux_ctl    (himux_ctl),
    .himux2_ctl   (himux2_ctl),
    .pc_sw_ctl    (pc_sw_ctl),
    .led          (led),
    .monitor      (monitor)
  );

  //////////////////////////////
  // helpers

  // returns 2 ns after a rising edge, where inputs change
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    assert (actual == expected)
    else
    begin
      errors++;
      $display("[ERROR] %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // pin fields put back together in control word order
  function automatic logic [NUM_BITS-1:0] pin_word();
    return {monitor, led, pc_sw_ctl, himux2_ctl, himux_ctl, azmux_ctl};
  endfunction

  // only the five defined indices keep a value, mode keeps two bits
  function automatic void store_model(input logic [ADDR_WIDTH-1:0] addr,
                                      input logic [REG_WIDTH-1:0] data);
    if (addr == ADDR_MODE)
      model[addr] = {{(REG_WIDTH - MODE_WIDTH){1'b0}}, data[MODE_WIDTH-1:0]};
    else if (addr >= ADDR_LED && addr <= ADDR_TEST_PATTERN)
      model[addr] = data;
  endfunction

  //////////////////////////////
  // spi master

  // mode 0, msb first, nbits below a full frame cuts it short
  task automatic spi_frame(input logic [ADDR_BITS-1:0] addr_byte,
                           input logic [REG_WIDTH-1:0] data, input int nbits,
                           output logic [REG_WIDTH-1:0] rdata);
    logic [FRAME_BITS-1:0] frame;
    int i;
    frame = {addr_byte, data};
    rdata = '0;
    spi_cs_n = 1'b0;
    wait_cycles(SPI_HALF);
    for (i = 0; i < nbits; i++)
    begin
      // data set up while sclk is low
      spi_mosi = frame[FRAME_BITS-1];
      frame = frame << 1;
      wait_cycles(SPI_HALF);
      // miso is captured at the rising edge, after the address byte
      if (i >= ADDR_BITS)
        rdata = {rdata[REG_WIDTH-2:0], spi_miso};
      spi_sclk = 1'b1;
      wait_cycles(SPI_HALF);
      spi_sclk = 1'b0;
    end
    wait_cycles(SPI_HALF);
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    // commit lands 4 cycles after release, pins one later
    wait_cycles(SETTLE_CYCLES);
  endtask

  task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr, input logic [REG_WIDTH-1:0] data);
    logic [REG_WIDTH-1:0] rdata;
    spi_frame({1'b1, addr}, data, FRAME_BITS, rdata);
    store_model(addr, data);
  endtask

  task automatic check_reg(input logic [ADDR_WIDTH-1:0] addr);
    logic [REG_WIDTH-1:0] rdata;
    spi_frame({1'b0, addr}, '0, FRAME_BITS, rdata);
    check_value(32'(rdata), 32'(model[addr]), $sformatf("readback of index %0d", addr));
  endtask

  // fan-out and miso against the routing rule
  task automatic check_route(input logic [NUM_PERIPH-1:0] mux, input logic active);
    logic [NUM_PERIPH-1:0] sel;
    logic [NUM_PERIPH-1:0] exp_cs;
    logic [2:0]            b;
    int                    i;
    sel = active ? mux : '0;
    for (i = 0; i < NUM_PERIPH; i++)
    begin
      b = i[2:0];
      exp_cs[b] = sel[b] ? CS_POLARITY[b] : ~CS_POLARITY[b];
    end
    check_value(32'(spi_cs_vec), 32'(exp_cs), "spi_cs_vec");
    check_value(32'(spi_sclk_vec), 32'(spi_sclk ? sel : 8'h00), "spi_sclk_vec");
    check_value(32'(spi_mosi_vec), 32'(spi_mosi ? sel : 8'h00), "spi_mosi_vec");
    check_value(32'(spi_miso), 32'((spi_miso_vec & sel) != 8'h00), "spi_miso from peripherals");
  endtask

  //////////////////////////////
  // watchdog

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////
  // test sequence

  initial
  begin
    logic [31:0]           rnd;
    logic [31:0]           rnd2;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  wr_flag;
    logic [REG_WIDTH-1:0]  rdata;
    logic [NUM_PERIPH-1:0] mux;
    logic [NUM_PERIPH-1:0] idle_cs;
    logic [NUM_BITS-1:0]   prev;
    logic [NUM_BITS-1:0]   curr;
    logic [NUM_BITS-1:0]   diff;
    logic [NUM_BITS-1:0]   dis_word;
    logic [NUM_BITS-1:0]   chg_word;
    logic [7:0]            prev_mon;
    logic                  seen_dis;
    logic                  seen_chg;
    int                    nbits;
    int                    n;
    int                    k;

    spi_sclk     = 1'b0;
    spi_cs_n     = 1'b1;
    spi_cs2_n    = 1'b1;
    spi_mosi     = 1'b0;
    spi_miso_vec = '0;
    seed         = 59722;
    errors       = 0;
    checks       = 0;
    for (n = 0; n < (1 << ADDR_WIDTH); n++)
      model[n[ADDR_WIDTH-1:0]] = '0;
    model[ADDR_MODE] = 24'(MODE_MCU);
    idle_cs = ~CS_POLARITY;

    wait (reset === 1'b1);
    wait (reset === 1'b0);
    wait_cycles(2);

    // reset state, pins low and selects idle
    check_value(32'(pin_word()), 32'd0, "control pins after reset");
    check_value(32'(oe_4094), 32'd0, "oe_4094 after reset");
    check_value(32'(spi_cs_vec), 32'(idle_cs), "spi_cs_vec after reset");
    for (n = 0; n < 8; n++)
      check_reg(n[ADDR_WIDTH-1:0]);

    // random frames, mostly on defined indices
    for (n = 0; n < NUM_RANDOM; n++)
    begin
      rnd  = $random(seed);
      rnd2 = $random(seed);
      if (rnd[2:0] == 3'd0)
        addr = rnd[14:8];
      else
        addr = 7'd1 + 7'(rnd[10:8] % 3'd5);
      wr_flag = rnd[3];
      // about one frame in eight is cut short and must change nothing
      nbits = (rnd[7:5] == 3'd0) ? 1 + int'(rnd[20:16]) % 31 : FRAME_BITS;
      spi_frame({wr_flag, addr}, rnd2[REG_WIDTH-1:0], nbits, rdata);
      if (nbits == FRAME_BITS)
      begin
        // readback is the value from before this frame's write
        check_value(32'(rdata), 32'(model[addr]), "readback within random frame");
        if (wr_flag)
          store_model(addr, rnd2[REG_WIDTH-1:0]);
      end
      check_reg(addr);
    end

    // mcu word straight to the pins
    write_reg(ADDR_MODE, 24'(MODE_MCU));
    for (n = 0; n < NUM_MCU_WORDS; n++)
    begin
      rnd  = $random(seed);
      rnd2 = $random(seed);
      write_reg(ADDR_TEST_PATTERN, rnd[REG_WIDTH-1:0]);
      write_reg(ADDR_4094, rnd2[REG_WIDTH-1:0]);
      check_value(32'(pin_word()), 32'(rnd[NUM_BITS-1:0]), "mcu word on pins");
      check_value(32'(oe_4094), 32'(rnd2[0]), "oe_4094 from reg_4094 bit 0");
    end

    // peripheral routing with cs2 low, then idle with cs2 high
    for (n = 0; n < NUM_ROUTES; n++)
    begin
      rnd = $random(seed);
      mux = rnd[NUM_PERIPH-1:0];
      write_reg(ADDR_SPI_MUX, {16'h0000, mux});
      spi_cs2_n = 1'b0;
      for (k = 0; k < 3; k++)
      begin
        rnd = $random(seed);
        spi_miso_vec = rnd[NUM_PERIPH-1:0];
        spi_sclk     = rnd[8];
        spi_mosi     = rnd[9];
        @(negedge clk);
        check_route(mux, 1'b1);
        wait_cycles(1);
      end
      spi_cs2_n = 1'b1;
      @(negedge clk);
      check_route(mux, 1'b0);
      wait_cycles(1);
      spi_sclk     = 1'b0;
      spi_mosi     = 1'b0;
      spi_miso_vec = '0;
      wait_cycles(1);
    end

    // counter mode, one step per clk between samples
    write_reg(ADDR_MODE, 24'(MODE_COUNTER));
    prev = pin_word();
    for (n = 0; n < NUM_SAMPLES; n++)
    begin
      wait_cycles(SAMPLE_GAP);
      curr = pin_word();
      diff = curr - prev;
      check_value(32'(diff), SAMPLE_GAP, "counter advance between samples");
      check_value(32'(curr != prev), 32'd1, "counter word repeated");
      prev = curr;
    end

    // pattern mode, muxes and pre-charge quiet, monitor moving
    write_reg(ADDR_MODE, 24'(MODE_PATTERN));
    prev_mon = monitor;
    for (n = 0; n < NUM_SAMPLES; n++)
    begin
      wait_cycles(SAMPLE_GAP);
      check_value(32'({azmux_ctl, himux_ctl, himux2_ctl, pc_sw_ctl}), 32'd0,
                  "pattern mux fields and pc_sw_ctl");
      check_value(32'(monitor != prev_mon), 32'd1, "pattern monitor stalled");
      prev_mon = monitor;
    end

    // charge mode, only the two sequencer words
    dis_word = {8'h00, 1'b0, 1'b0, HIMUX2_SEL_GND, HIMUX_SEL_HIMUX2, 4'h0};
    chg_word = {8'h00, 1'b1, 1'b0, HIMUX2_SEL_DCV, HIMUX_SEL_HIMUX2, 4'h0};
    seen_dis = 1'b0;
    seen_chg = 1'b0;
    write_reg(ADDR_MODE, 24'(MODE_CHARGE));
    for (n = 0; n < CHARGE_SPAN / CHARGE_GAP; n++)
    begin
      wait_cycles(CHARGE_GAP);
      curr = pin_word();
      if (curr == dis_word)
        seen_dis = 1'b1;
      if (curr == chg_word)
        seen_chg = 1'b1;
      check_value(32'(curr == dis_word || curr == chg_word), 32'd1, "charge word");
      check_value(32'(led), 32'(himux2_ctl == HIMUX2_SEL_DCV), "led against himux2");
    end
    check_value(32'(seen_dis && seen_chg), 32'd1, "both charge phases seen");

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
src/dmm_ctl_pkg.sv
src/spi_reg_bank.sv
src/spi_periph_route.sv
src/pattern_gen.sv
src/charge_sequencer.sv
src/output_select.sv
src/dmm_ctl_top.sv
tb/tb_clock.sv
tb/dmm_ctl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
# the run passes only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module dmm_ctl_tb -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vdmm_ctl_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
fi

echo "pass line not found in simulation output"
exit 1
